// ==== common/Common.sv ====
package Common;

    typedef logic [31:0] uint32;    // Address and data word
    typedef logic [3:0]  byteMask;  // One bit per byte lane, lane 0 is LSB
    typedef logic [3:0]  memOp;     // {valid, store, size/sign}

    // Memory operation encodings
    localparam memOp opLb  = 4'b1000;  // Load byte, sign extended
    localparam memOp opLh  = 4'b1001;  // Load half, sign extended
    localparam memOp opLw  = 4'b1010;  // Load word
    localparam memOp opLbu = 4'b1011;  // Load byte, zero extended
    localparam memOp opSb  = 4'b1100;
    localparam memOp opSh  = 4'b1101;
    localparam memOp opSw  = 4'b1110;
    localparam memOp opLhu = 4'b1111;  // Load half, zero extended

    // LHU carries the store bit but is a load, so decode stores by code
    function automatic logic isStoreOp(memOp code);
        return (code == opSb) || (code == opSh) || (code == opSw);
    endfunction

    // Low address bits that must be zero for the access size
    function automatic logic [1:0] alignMask(memOp code);
        logic [1:0] mask;
        case (code)
            opLh, opLhu, opSh: mask = 2'b01;
            opLw, opSw:        mask = 2'b11;
            default:           mask = 2'b00;  // Bytes and invalid codes
        endcase
        return mask;
    endfunction

endpackage

// ==== memAccess/memAccessCtrl.sv ====
`timescale 1ns/1ps

module memAccessCtrl #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  Common::memOp                op,
    input  Common::uint32               addr,
    input  Common::uint32               storeData,
    output logic [$clog2(memWords)-1:0] ramIndex,
    output Common::byteMask             ramMask,
    output Common::uint32               ramWrData,
    output logic                        ramRead,
    output logic                        s1Valid,
    output Common::memOp                s1Op,
    output logic [1:0]                  s1Lane,
    output logic                        s1Fault
);
    import Common::*;

    localparam int idxBits = $clog2(memWords);

    logic [1:0]         lane;
    logic               opValid;
    logic               storeOp;
    logic               fault;
    logic [idxBits-1:0] wordIndex;
    byteMask            laneMask;
    uint32              laneData;

    assign lane      = addr[1:0];
    assign opValid   = op[3];
    assign storeOp   = isStoreOp(op);
    assign wordIndex = addr[idxBits+1:2];  // Wraps modulo memWords

    // Half needs bit 0 clear and word needs both low bits clear
    assign fault = opValid && (|(lane & alignMask(op)));

    // Lane mask and lane-placed store data
    always_comb begin
        laneMask = '0;
        laneData = storeData;
        case (op)
            opSb: begin
                laneMask = 4'b0001 << lane;
                laneData = {4{storeData[7:0]}};  // Byte in every lane
            end
            opSh: begin
                laneMask = 4'b0011 << lane;
                laneData = {2{storeData[15:0]}};  // Half in both halves
            end
            opSw: begin
                laneMask = 4'b1111;
                laneData = storeData;
            end
            default: begin
                laneMask = '0;  // Loads and invalid codes
            end
        endcase
    end

    // Stage 1 control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ramMask <= '0;
            ramRead <= 1'b0;
            s1Valid <= 1'b0;
            s1Fault <= 1'b0;
        end else begin
            ramMask <= (storeOp && !fault) ? laneMask : '0;
            ramRead <= opValid && !storeOp && !fault;
            s1Valid <= opValid;
            s1Fault <= fault;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        ramIndex  <= wordIndex;
        ramWrData <= laneData;
        s1Op      <= op;
        s1Lane    <= lane;  // Byte select for load alignment
    end

    // Never write and read the RAM in the same cycle
    maskReadExcl: assert property (
        @(posedge clk) disable iff (!rstN)
        !(ramRead && (|ramMask))
    ) else $error("ramMask set together with ramRead");

    // A misaligned access reaches stage 1 flagged and touches no RAM port
    faultNoAccess: assert property (
        @(posedge clk) disable iff (!rstN)
        fault |=> (s1Fault && s1Valid && ramMask == '0 && !ramRead)
    ) else $error("fault produced a RAM access");

endmodule

// ==== memAccess/loadAlign.sv ====
`timescale 1ns/1ps

module loadAlign (
    input  logic          clk,
    input  logic          rstN,
    input  logic          s1Valid,
    input  Common::memOp  s1Op,
    input  logic [1:0]    s1Lane,
    input  logic          s1Fault,
    input  Common::uint32 ramRdData,
    output logic          respValid,
    output logic          respStore,
    output logic          exception,
    output Common::uint32 loadData
);
    import Common::*;

    logic       s2Valid;
    logic       s2Fault;
    memOp       s2Op;
    logic [1:0] s2Lane;
    logic [7:0]  byteSel;
    logic [15:0] halfSel;
    uint32      extData;

    // Side band delayed to line up with RAM read data
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s2Valid <= 1'b0;
            s2Fault <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
            s2Fault <= s1Fault;
        end
    end

    always_ff @(posedge clk) begin
        s2Op   <= s1Op;
        s2Lane <= s1Lane;
    end

    assign byteSel = ramRdData[8*s2Lane +: 8];
    assign halfSel = ramRdData[16*s2Lane[1] +: 16];  // Aligned halves sit at lane 0 or 2

    always_comb begin
        case (s2Op)
            opLb:    extData = {{24{byteSel[7]}}, byteSel};
            opLbu:   extData = {24'd0, byteSel};
            opLh:    extData = {{16{halfSel[15]}}, halfSel};
            opLhu:   extData = {16'd0, halfSel};
            opLw:    extData = ramRdData;
            default: extData = '0;  // Stores return zero
        endcase
    end

    // Stage 3 result
    always_ff @(posedge clk) begin
        if (!rstN) begin
            respValid <= 1'b0;
            respStore <= 1'b0;
            exception <= 1'b0;
        end else begin
            respValid <= s2Valid;
            respStore <= s2Valid && isStoreOp(s2Op);
            exception <= s2Valid && s2Fault;
        end
    end

    always_ff @(posedge clk) begin
        loadData <= (s2Valid && !s2Fault) ? extData : '0;  // Faults return zero
    end

    excHasResp: assert property (
        @(posedge clk) disable iff (!rstN)
        exception |-> respValid
    ) else $error("exception without respValid");

endmodule

// ==== verilog/dataRam.sv ====
`timescale 1ns/1ps

module dataRam #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic [$clog2(memWords)-1:0] ramIndex,
    input  Common::byteMask             ramMask,
    input  Common::uint32               ramWrData,
    input  logic                        ramRead,
    output Common::uint32               ramRdData
);
    import Common::*;

    uint32 mem [memWords];  // No reset on contents

    // One write enable per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (ramMask[b]) begin
                mem[ramIndex][8*b +: 8] <= ramWrData[8*b +: 8];
            end
        end
    end

    // Registered read, holds between load strobes
    always_ff @(posedge clk) begin
        if (ramRead) begin
            ramRdData <= mem[ramIndex];
        end
    end

endmodule

// ==== verilog/memStage.sv ====
`timescale 1ns/1ps

module memStage #(
    parameter int memWords = 256
) (
    input  logic          clk,
    input  logic          rstN,
    input  Common::memOp  op,
    input  Common::uint32 addr,
    input  Common::uint32 storeData,
    output logic          respValid,
    output logic          respStore,
    output logic          exception,
    output Common::uint32 loadData
);
    import Common::*;

    localparam int idxBits = $clog2(memWords);

    logic [idxBits-1:0] ramIndex;
    byteMask            ramMask;
    uint32              ramWrData;
    logic               ramRead;
    uint32              ramRdData;
    logic               s1Valid;
    memOp               s1Op;
    logic [1:0]         s1Lane;
    logic               s1Fault;

    // Stage 1 decode and alignment
    memAccessCtrl #(
        .memWords (memWords)
    ) memAccessCtrl_inst (
        .clk       (clk),
        .rstN      (rstN),
        .op        (op),
        .addr      (addr),
        .storeData (storeData),
        .ramIndex  (ramIndex),
        .ramMask   (ramMask),
        .ramWrData (ramWrData),
        .ramRead   (ramRead),
        .s1Valid   (s1Valid),
        .s1Op      (s1Op),
        .s1Lane    (s1Lane),
        .s1Fault   (s1Fault)
    );

    // Stage 2 data RAM
    dataRam #(
        .memWords (memWords)
    ) dataRam_inst (
        .clk       (clk),
        .ramIndex  (ramIndex),
        .ramMask   (ramMask),
        .ramWrData (ramWrData),
        .ramRead   (ramRead),
        .ramRdData (ramRdData)
    );

    // Stage 3 load extraction and response
    loadAlign loadAlign_inst (
        .clk       (clk),
        .rstN      (rstN),
        .s1Valid   (s1Valid),
        .s1Op      (s1Op),
        .s1Lane    (s1Lane),
        .s1Fault   (s1Fault),
        .ramRdData (ramRdData),
        .respValid (respValid),
        .respStore (respStore),
        .exception (exception),
        .loadData  (loadData)
    );

endmodule

// ==== verif/memModel.svh ====
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// Byte shadow of the 16 words that the stimulus reaches, byte address 0 to 63
logic [7:0] shadow [64];

// Halfwords need bit 0 clear, words need both low bits clear
function automatic logic expectedFault(memOp code, uint32 a);
    logic fault;
    case (code)
        opLh, opLhu, opSh: fault = a[0];
        opLw, opSw:        fault = (a[1:0] != 2'b00);
        default:           fault = 1'b0;
    endcase
    return fault;
endfunction

// LHU shares the store bit but is a load
function automatic logic expectedStore(memOp code);
    return code[3] && code[2] && (code[1:0] != 2'b11);
endfunction

function automatic uint32 expectedLoad(memOp code, uint32 a);
    logic [5:0] b0;
    logic [5:0] b1;
    logic [5:0] b2;
    logic [5:0] b3;
    uint32      value;
    b0 = a[5:0];
    b1 = b0 + 6'd1;
    b2 = b0 + 6'd2;
    b3 = b0 + 6'd3;
    case (code)
        opLb:    value = {{24{shadow[b0][7]}}, shadow[b0]};
        opLbu:   value = {24'd0, shadow[b0]};
        opLh:    value = {{16{shadow[b1][7]}}, shadow[b1], shadow[b0]};
        opLhu:   value = {16'd0, shadow[b1], shadow[b0]};
        opLw:    value = {shadow[b3], shadow[b2], shadow[b1], shadow[b0]};
        default: value = '0;
    endcase
    return value;
endfunction

// Aligned stores only, the caller filters faults
task automatic applyStore(memOp code, uint32 a, uint32 d);
    logic [5:0] b0;
    b0 = a[5:0];
    case (code)
        opSb: shadow[b0] = d[7:0];
        opSh: begin
            shadow[b0]        = d[7:0];
            shadow[b0 + 6'd1] = d[15:8];
        end
        opSw: begin
            shadow[b0]        = d[7:0];
            shadow[b0 + 6'd1] = d[15:8];
            shadow[b0 + 6'd2] = d[23:16];
            shadow[b0 + 6'd3] = d[31:24];
        end
        default: ;
    endcase
endtask

`endif

// ==== verif/memStageTb.sv ====
`timescale 1ns/1ps

module memStageTb;
    import Common::*;

    `include "memModel.svh"

    logic  clk = 1'b0;
    logic  rstN;
    memOp  op;
    uint32 addr;
    uint32 storeData;
    logic  respValid;
    logic  respStore;
    logic  exception;
    uint32 loadData;

    // Expected result of the op the DUT samples at the next edge
    logic  nextValid = 1'b0;
    logic  nextStore = 1'b0;
    logic  nextExc = 1'b0;
    uint32 nextData = '0;
    memOp  nextOp = '0;

    // Delay line indexed by the fixed latency of 3 edges
    logic  expValid [3];
    logic  expStore [3];
    logic  expExc [3];
    uint32 expData [3];
    memOp  expOp [3];

    uint32 lfsrState = 32'h401d;

    memStage #(
        .memWords (256)
    ) memStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .op        (op),
        .addr      (addr),
        .storeData (storeData),
        .respValid (respValid),
        .respStore (respStore),
        .exception (exception),
        .loadData  (loadData)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 3; i++) begin
                expValid[i] <= 1'b0;
                expStore[i] <= 1'b0;
                expExc[i]   <= 1'b0;
                expData[i]  <= '0;
                expOp[i]    <= '0;
            end
        end else begin
            expValid[0] <= nextValid;
            expStore[0] <= nextStore;
            expExc[0]   <= nextExc;
            expData[0]  <= nextData;
            expOp[0]    <= nextOp;
            for (int i = 1; i < 3; i++) begin
                expValid[i] <= expValid[i-1];
                expStore[i] <= expStore[i-1];
                expExc[i]   <= expExc[i-1];
                expData[i]  <= expData[i-1];
                expOp[i]    <= expOp[i-1];
            end
        end
    end

    // Taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic uint32 takeBits(int count);
        uint32 bits;
        logic  fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic string opName(memOp code);
        string name;
        case (code)
            opLb:    name = "LB";
            opLh:    name = "LH";
            opLw:    name = "LW";
            opLbu:   name = "LBU";
            opSb:    name = "SB";
            opSh:    name = "SH";
            opSw:    name = "SW";
            opLhu:   name = "LHU";
            default: name = "idle";
        endcase
        return name;
    endfunction

    task automatic stopOnFailure();
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic reportMismatch(string check, memOp code, uint32 expected, uint32 actual);
        $display("mismatch %s %s expected %08h actual %08h", check, opName(code), expected,
                 actual);
        stopOnFailure();
    endtask

    // Computes the expected response at issue time, so program order holds
    task automatic issueOp(memOp code, uint32 a, uint32 d);
        logic  fault;
        logic  isStore;
        logic  aligned;
        uint32 result;
        @(posedge clk);
        fault   = expectedFault(code, a);
        isStore = expectedStore(code);
        aligned = code[3] && !fault;
        result  = '0;
        if (aligned && !isStore) begin
            result = expectedLoad(code, a);
        end
        if (aligned && isStore) begin
            applyStore(code, a, d);
        end
        op        <= code;
        addr      <= a;
        storeData <= d;
        nextValid <= code[3];
        nextStore <= code[3] && isStore;
        nextExc   <= code[3] && fault;
        nextData  <= result;
        nextOp    <= code;
    endtask

    respValidCheck: assert property (
        @(posedge clk) disable iff (!rstN)
        respValid == expValid[2]
    ) else reportMismatch("respValid", $sampled(expOp[2]), {31'd0, $sampled(expValid[2])},
                          {31'd0, $sampled(respValid)});

    exceptionCheck: assert property (
        @(posedge clk) disable iff (!rstN)
        exception == expExc[2]
    ) else reportMismatch("exception", $sampled(expOp[2]), {31'd0, $sampled(expExc[2])},
                          {31'd0, $sampled(exception)});

    respStoreCheck: assert property (
        @(posedge clk) disable iff (!rstN)
        expValid[2] |-> respStore == expStore[2]
    ) else reportMismatch("respStore", $sampled(expOp[2]), {31'd0, $sampled(expStore[2])},
                          {31'd0, $sampled(respStore)});

    loadDataCheck: assert property (
        @(posedge clk) disable iff (!rstN)
        expValid[2] |-> loadData == expData[2]
    ) else reportMismatch("loadData", $sampled(expOp[2]), $sampled(expData[2]),
                          $sampled(loadData));

    initial begin
        uint32      bits;
        uint32      a;
        uint32      d;
        uint32      base;
        memOp       code;
        logic [1:0] lane;
        int         waitCycles;
        rstN      <= 1'b0;
        op        <= '0;
        addr      <= '0;
        storeData <= '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // Outputs must settle idle once reset is gone
        waitCycles = 0;
        while ((respValid !== 1'b0 || exception !== 1'b0) && waitCycles < 16) begin
            @(posedge clk);
            waitCycles++;
        end
        if (respValid !== 1'b0 || exception !== 1'b0) begin
            $display("outputs did not go idle after reset");
            stopOnFailure();
        end

        for (int w = 0; w < 16; w++) begin
            issueOp(opSw, w * 4, takeBits(32));  // Fill every word before the first load
        end

        for (int w = 0; w < 16; w++) begin
            base = w * 4;
            lane = base[5:4];
            issueOp(opSb, base + {30'd0, lane}, takeBits(32));
            issueOp(opLw, base, '0);
            issueOp(opSh, base + {30'd0, lane[1], 1'b0}, takeBits(32));
            issueOp(opLh, base + {30'd0, lane[1], 1'b0}, '0);
            issueOp(opSw, base + 32'd1, takeBits(32));  // Misaligned so memory must not change
            issueOp(opSh, base + 32'd3, takeBits(32));
            issueOp(opLw, base, '0);
            issueOp(opLhu, base + 32'd1, '0);
            issueOp(opLbu, base + {30'd0, lane}, '0);
            issueOp(4'b0110, base, takeBits(32));  // Invalid code
        end

        for (int n = 0; n < 3000; n++) begin
            bits = takeBits(4);
            code = bits[3:0];
            bits = takeBits(6);
            a    = {26'd0, bits[5:0]};
            d    = takeBits(32);
            issueOp(code, a, d);
        end
        issueOp(4'b0000, '0, '0);

        waitCycles = 0;
        while ((expValid[0] | expValid[1] | expValid[2] | respValid) == 1'b1 &&
               waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if ((expValid[0] | expValid[1] | expValid[2] | respValid) == 1'b1) begin
            $display("pipeline did not drain after the last operation");
            stopOnFailure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== memStage.f ====
+incdir+verif
common/Common.sv
memAccess/memAccessCtrl.sv
memAccess/loadAlign.sv
verilog/dataRam.sv
verilog/memStage.sv
verif/memStageTb.sv

// ==== Makefile ====
# Verilator build and run for the memory-access stage testbench

VERILATOR ?= verilator
TOP       ?= memStageTb
FLAGS     ?= --binary --timing --assert
OBJDIR    ?= obj_dir
FILELIST  ?= memStage.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verif/*.svh)
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes
$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
